//--- verilog/shmem_defines.svh
/*
  sizing of the shared memory subsystem
*/
`ifndef SHMEM_DEFINES_SVH
`define SHMEM_DEFINES_SVH

////////////////////
// port count
////////////////////

// number of client ports that share the single memory bank
`define SHMEM_NUM_PORTS 4

////////////////////
// bank geometry
////////////////////

// word address width, the bank depth follows as 2**SHMEM_ADDR_W words
`define SHMEM_ADDR_W 6
// width of one data word
`define SHMEM_DATA_W 32

`endif

//--- verilog/arb_pkg.sv
/*
  arbitration types, the port number and the per-port bit vector
*/
`include "shmem_defines.svh"

package arb_pkg;

  ////////////////////
  // port numbering
  ////////////////////

  // number of one client port, also the tag carried by a response
  typedef logic [$clog2(`SHMEM_NUM_PORTS)-1:0] port_idx_t;

  // one bit per client port
  // used for pending, busy and grant vectors
  typedef logic [`SHMEM_NUM_PORTS-1:0] port_vec_t;

endpackage

//--- verilog/mem_bus_pkg.sv
/*
  memory bus types, the request a client issues and the tagged response
*/
`include "shmem_defines.svh"

package mem_bus_pkg;

  import arb_pkg::*;

  ////////////////////
  // field types
  ////////////////////

  // word address into the bank
  typedef logic [`SHMEM_ADDR_W-1:0] addr_t;
  // one data word
  typedef logic [`SHMEM_DATA_W-1:0] data_t;

  ////////////////////
  // request
  ////////////////////

  // a client request, a write when we is set and a read otherwise
  // wdata is ignored by the bank on a read
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  ////////////////////
  // response
  ////////////////////

  // idx names the port that issued the request
  // for a write rdata carries the word that was overwritten
  typedef struct packed {
    port_idx_t idx;
    logic      we;
    data_t     rdata;
  } mem_rsp_t;

endpackage

//--- verilog/lzc.sv
/*
  trailing-zero counter
  returns the index of the lowest set bit and flags an all-zero input
*/
module lzc #(
  parameter  int unsigned WIDTH = 4,
  localparam int unsigned CntW  = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0] in_i,
  output logic [CntW-1:0]  cnt_o,
  output logic             empty_o
);

  ////////////////////
  // lowest set bit
  ////////////////////

  // the scan runs from the top bit down so that the lowest set bit
  // is the last one to write the count
  // the count equals the number of trailing zeros
  always_comb begin : p_scan
    cnt_o = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        cnt_o = CntW'(i);
      end
    end
  end

  ////////////////////
  // empty flag
  ////////////////////

  // with no bit set the count stays at zero
  // so the caller has to look at this flag before using it
  assign empty_o = ~|in_i;

endmodule

//--- verilog/rr_arb_tree.sv
/*
  round-robin arbitration tree
  grants one pending input per cycle and forwards its payload and index
*/
module rr_arb_tree import arb_pkg::*; #(
  parameter int unsigned NumIn    = $bits(port_vec_t),
  parameter type         DataType = logic [31:0],
  parameter bit          FairArb  = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  port_vec_t           req_i,
  output port_vec_t           gnt_o,
  input  DataType [NumIn-1:0] data_i,
  output logic                req_o,
  input  logic                gnt_i,
  output DataType             data_o,
  output port_idx_t           idx_o
);

  localparam int unsigned NumLevels = $clog2(NumIn);
  localparam int unsigned NumLeaves = 2 ** NumLevels;
  localparam int unsigned NumNodes  = NumLeaves - 1;

  // the request and index types are sized by the port count
  if (NumIn != $bits(port_vec_t)) begin : gen_num_in_check
    $error("rr_arb_tree needs NumIn equal to the port vector width");
  end

  port_idx_t                 rr_q;
  port_idx_t                 rr_d;
  logic      [NumIn-1:0]     prio_mask;
  logic      [NumIn-1:0]     req_sel;
  logic      [NumLeaves-1:0] req_pad;
  logic      [NumLeaves-1:0] gnt_pad;
  DataType   [NumLeaves-1:0] data_pad;
  logic      [NumNodes-1:0]  req_nodes;
  logic      [NumNodes-1:0]  gnt_nodes;
  port_idx_t [NumNodes-1:0]  idx_nodes;
  DataType   [NumNodes-1:0]  data_nodes;

  ////////////////////
  // priority window
  ////////////////////

  // requests at or above the pointer win over those below it
  // if none sits at or above the pointer the search wraps to the lowest pending port
  for (genvar i = 0; i < NumIn; i++) begin : gen_prio_mask
    assign prio_mask[i] = req_i[i] & (port_idx_t'(i) >= rr_q);
  end

  assign req_sel = (|prio_mask) ? prio_mask : req_i;

  // the tree is padded up to a full binary tree whose extra leaves never request
  always_comb begin : p_pad
    req_pad               = '0;
    data_pad              = '0;
    req_pad[NumIn-1:0]    = req_sel;
    data_pad[NumIn-1:0]   = data_i;
  end

  ////////////////////
  // select tree
  ////////////////////

  // every node favours its lower child when that child requests
  // so the root ends up at the lowest index of the selected window
  // the grant from the bank walks back down the same path
  assign gnt_nodes[0] = gnt_i;

  for (genvar lvl = 0; lvl < NumLevels; lvl++) begin : gen_levels
    for (genvar n = 0; n < 2 ** lvl; n++) begin : gen_nodes
      localparam int unsigned Node = 2 ** lvl - 1 + n;
      localparam int unsigned Kid  = 2 ** (lvl + 1) - 1 + 2 * n;
      logic sel;

      if (lvl == NumLevels - 1) begin : gen_leaf
        // leaf nodes look straight at a pair of inputs
        assign req_nodes[Node]  = req_pad[2*n] | req_pad[2*n+1];
        assign sel              = ~req_pad[2*n];
        assign idx_nodes[Node]  = port_idx_t'(sel);
        assign data_nodes[Node] = sel ? data_pad[2*n+1] : data_pad[2*n];
        assign gnt_pad[2*n]     = gnt_nodes[Node] & req_pad[2*n];
        assign gnt_pad[2*n+1]   = gnt_nodes[Node] & req_pad[2*n+1] & sel;
      end else begin : gen_inner
        // inner nodes prepend their select bit to the index of the chosen child
        assign req_nodes[Node]  = req_nodes[Kid] | req_nodes[Kid+1];
        assign sel              = ~req_nodes[Kid];
        assign idx_nodes[Node]  = sel ?
          port_idx_t'({1'b1, idx_nodes[Kid+1][NumLevels-lvl-2:0]}) :
          port_idx_t'({1'b0, idx_nodes[Kid][NumLevels-lvl-2:0]});
        assign data_nodes[Node] = sel ? data_nodes[Kid+1] : data_nodes[Kid];
        assign gnt_nodes[Kid]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Kid+1] = gnt_nodes[Node] & sel;
      end
    end
  end

  // the root carries the decision
  assign req_o  = req_nodes[0];
  assign data_o = data_nodes[0];
  assign idx_o  = idx_nodes[0];
  assign gnt_o  = gnt_pad[NumIn-1:0];

  ////////////////////
  // pointer update
  ////////////////////

  if (FairArb) begin : gen_fair
    logic [NumIn-1:0] upper_mask;
    logic [NumIn-1:0] lower_mask;
    port_idx_t        upper_idx;
    port_idx_t        lower_idx;
    logic             upper_empty;

    // pending ports strictly above the pointer, and the wrapped rest
    for (genvar i = 0; i < NumIn; i++) begin : gen_masks
      assign upper_mask[i] = req_i[i] & (port_idx_t'(i) > rr_q);
      assign lower_mask[i] = req_i[i] & (port_idx_t'(i) <= rr_q);
    end

    lzc #(
      .WIDTH (NumIn)
    ) u_lzc_upper (
      .in_i    (upper_mask),
      .cnt_o   (upper_idx),
      .empty_o (upper_empty)
    );

    // a grant implies at least one request, so the wrapped side is never empty here
    lzc #(
      .WIDTH (NumIn)
    ) u_lzc_lower (
      .in_i    (lower_mask),
      .cnt_o   (lower_idx),
      .empty_o ()
    );

    assign rr_d = (req_o && gnt_i) ? (upper_empty ? lower_idx : upper_idx) : rr_q;
  end else begin : gen_step
    // plain rotation by one per grant, blind to which ports are pending
    assign rr_d = (req_o && gnt_i) ?
      ((rr_q == port_idx_t'(NumIn - 1)) ? '0 : rr_q + 1'b1) : rr_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("rr_arb_tree grants more than one input");

  // the grant path and the index path of the tree have to agree on the winner
  a_gnt_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |gnt_o |-> gnt_i && gnt_o[idx_o])
    else $error("rr_arb_tree grants without the bank or away from the forwarded index");

  a_req_is_or: assert property (@(posedge clk_i) disable iff (!rst_ni) req_o == |req_i)
    else $error("rr_arb_tree request out differs from the OR of its inputs");

endmodule

//--- verilog/port_req_reg.sv
/*
  per-port holding register
  keeps one client request from its strobe until the arbiter grants it
*/
module port_req_reg import mem_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     valid_i,
  input  mem_req_t req_i,
  input  logic     gnt_i,
  output logic     pending_o,
  output mem_req_t req_o
);

  logic     pending_q;
  mem_req_t req_q;

  ////////////////////
  // pending flag
  ////////////////////

  // flush drops the request whatever else happens in the cycle
  // a strobe only arrives while idle, so it never meets a grant
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (flush_i) begin
      pending_q <= 1'b0;
    end else if (valid_i) begin
      pending_q <= 1'b1;
    end else if (gnt_i) begin
      pending_q <= 1'b0;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // the struct is taken on the strobe and stays put until the next strobe
  always_ff @(posedge clk_i) begin : p_payload
    if (valid_i) begin
      req_q <= req_i;
    end
  end

  assign pending_o = pending_q;
  assign req_o     = req_q;

  // the client must wait for busy to drop before it strobes again
  a_no_strobe_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> !pending_q)
    else $error("port_req_reg strobed while a request is still pending");

endmodule

//--- verilog/sram_bank.sv
/*
  single-port memory bank
  performs one access per ready cycle and returns a tagged response a cycle later
*/
module sram_bank import arb_pkg::*, mem_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      bank_busy_i,
  input  logic      req_i,
  input  port_idx_t idx_i,
  input  mem_req_t  data_i,
  output logic      ready_o,
  output logic      rsp_valid_o,
  output mem_rsp_t  rsp_o
);

  localparam int unsigned Depth = 2 ** $bits(addr_t);

  data_t    mem_q [Depth];
  logic     accept;
  logic     rsp_valid_q;
  mem_rsp_t rsp_q;

  ////////////////////
  // accept
  ////////////////////

  // the busy level is the only thing that holds the bank back
  assign ready_o = ~bank_busy_i;
  assign accept  = req_i & ready_o;

  ////////////////////
  // storage
  ////////////////////

  // the response reads the word before the write lands
  // so a write returns the old contents of its address
  always_ff @(posedge clk_i) begin : p_array
    if (accept) begin
      rsp_q.idx   <= idx_i;
      rsp_q.we    <= data_i.we;
      rsp_q.rdata <= mem_q[data_i.addr];
      if (data_i.we) begin
        mem_q[data_i.addr] <= data_i.wdata;
      end
    end
  end

  ////////////////////
  // response valid
  ////////////////////

  // high for exactly one cycle after every accepted access
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rsp_valid
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // a stalled cycle must never produce a response on the next one
  a_rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> $past(req_i) && !$past(bank_busy_i))
    else $error("sram_bank responded without an accepted request");

endmodule

//--- verilog/shmem_top.sv
/*
  shared memory subsystem
  four client ports share one bank through a round-robin arbiter
*/
`include "shmem_defines.svh"

module shmem_top import arb_pkg::*, mem_bus_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  port_vec_t                           req_valid_i,
  input  mem_req_t [`SHMEM_NUM_PORTS-1:0]     req_i,
  output port_vec_t                           busy_o,
  input  logic                                bank_busy_i,
  output logic                                rsp_valid_o,
  output mem_rsp_t                            rsp_o
);

  port_vec_t                         pending;
  port_vec_t                         port_gnt;
  mem_req_t [`SHMEM_NUM_PORTS-1:0]   held_req;
  logic                              arb_req;
  mem_req_t                          arb_data;
  port_idx_t                         arb_idx;
  logic                              bank_ready;

  ////////////////////
  // client ports
  ////////////////////

  // one holding register per port, busy is simply its pending flag
  for (genvar p = 0; p < `SHMEM_NUM_PORTS; p++) begin : gen_ports
    port_req_reg u_port_req_reg (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .flush_i   (flush_i),
      .valid_i   (req_valid_i[p]),
      .req_i     (req_i[p]),
      .gnt_i     (port_gnt[p]),
      .pending_o (pending[p]),
      .req_o     (held_req[p])
    );
  end

  assign busy_o = pending;

  ////////////////////
  // arbiter
  ////////////////////

  // the bank ready level acts as the grant into the tree
  rr_arb_tree #(
    .NumIn    (`SHMEM_NUM_PORTS),
    .DataType (mem_req_t),
    .FairArb  (1'b1)
  ) u_rr_arb_tree (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (pending),
    .gnt_o   (port_gnt),
    .data_i  (held_req),
    .req_o   (arb_req),
    .gnt_i   (bank_ready),
    .data_o  (arb_data),
    .idx_o   (arb_idx)
  );

  ////////////////////
  // bank
  ////////////////////

  sram_bank u_sram_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bank_busy_i (bank_busy_i),
    .req_i       (arb_req),
    .idx_i       (arb_idx),
    .data_i      (arb_data),
    .ready_o     (bank_ready),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

//--- verif/tb_shmem.sv
/*
  testbench for the shared memory subsystem
  drives the four client ports and checks every response against a reference model
*/
`include "shmem_defines.svh"

module tb_shmem import arb_pkg::*, mem_bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP         = `SHMEM_NUM_PORTS;
  localparam int DEPTH      = 1 << `SHMEM_ADDR_W;
  localparam int NUM_RANDOM = 200;
  // preload takes about 100 cycles and the directed tests about 60
  // the random test needs at most a few hundred, so this leaves a wide margin
  localparam int MAX_CYCLES = 3000;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  port_vec_t         req_valid_i;
  mem_req_t [NP-1:0] req_i;
  port_vec_t         busy_o;
  logic              bank_busy_i;
  logic              rsp_valid_o;
  mem_rsp_t          rsp_o;

  // one payload per port for the next strobe
  mem_req_t [NP-1:0] req_drv;

  // reference model of the ports, the pointer and the bank
  port_vec_t         m_pending;
  mem_req_t [NP-1:0] m_req;
  port_idx_t         m_ptr;
  logic              m_rsp_valid;
  mem_rsp_t          m_rsp;
  logic              m_rsp_known;
  data_t             ref_mem [DEPTH];
  logic              ref_known [DEPTH];
  mem_rsp_t          rsp_log [$];
  int                cycle_cnt = 0;

  shmem_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .bank_busy_i (bank_busy_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  ////////////////////
  // clock and timeout
  ////////////////////

  initial begin : p_clock
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : p_timeout
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // before the preload an old word is unknown, then only tag and write flag count
  task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input logic known);
    if (known ? (got !== exp) : (got.idx !== exp.idx || got.we !== exp.we)) begin
      mismatch($sformatf("rsp_o idx %0d we %0b rdata %h, expected idx %0d we %0b rdata %h",
                         got.idx, got.we, got.rdata, exp.idx, exp.we, exp.rdata));
    end
  endtask

  task automatic check_busy(input port_vec_t got, input port_vec_t exp);
    if (got !== exp) begin
      mismatch($sformatf("busy_o is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      mismatch($sformatf("rsp_valid_o is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_idx(input port_idx_t got, input port_idx_t exp);
    if (got !== exp) begin
      mismatch($sformatf("response tag is port %0d, expected port %0d", got, exp));
    end
  endtask

  ////////////////////
  // arbitration model
  ////////////////////

  // first pending port at or above the pointer, counted cyclically
  function automatic port_idx_t pick_winner(input port_vec_t pend, input port_idx_t ptr);
    port_idx_t cand;
    logic      found;
    found       = 1'b0;
    pick_winner = '0;
    for (int k = 0; k < NP; k++) begin
      cand = port_idx_t'((int'(ptr) + k) % NP);
      if (!found && pend[cand]) begin
        pick_winner = cand;
        found       = 1'b1;
      end
    end
  endfunction

  // lowest pending index above the pointer, else the lowest one at or below it
  function automatic port_idx_t next_pointer(input port_vec_t pend, input port_idx_t ptr);
    logic found;
    found        = 1'b0;
    next_pointer = ptr;
    for (int i = 0; i < NP; i++) begin
      if (!found && pend[i] && i > int'(ptr)) begin
        next_pointer = port_idx_t'(i);
        found        = 1'b1;
      end
    end
    for (int i = 0; i < NP; i++) begin
      if (!found && pend[i] && i <= int'(ptr)) begin
        next_pointer = port_idx_t'(i);
        found        = 1'b1;
      end
    end
  endfunction

  function automatic port_vec_t one_port(input int p);
    one_port    = '0;
    one_port[p] = 1'b1;
  endfunction

  // preload contents where every address bit changes the word
  function automatic data_t fill_word(input addr_t a);
    fill_word = data_t'(32'hC0DE_0000) ^ (data_t'(a) << 20) ^ data_t'(a);
  endfunction

  task automatic model_reset();
    m_pending   = '0;
    m_ptr       = '0;
    m_rsp_valid = 1'b0;
    m_rsp       = '0;
    m_rsp_known = 1'b0;
  endtask

  ////////////////////
  // driving
  ////////////////////

  task automatic apply_reset();
    rst_ni      = 1'b0;
    req_valid_i = '0;
    flush_i     = 1'b0;
    bank_busy_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    model_reset();
    check_busy(busy_o, '0);
    check_valid(rsp_valid_o, 1'b0);
  endtask

  // one clock cycle, called 1 ns after a rising edge
  // the model moves to the state the next edge produces and the DUT is checked after it
  task automatic step(input port_vec_t strobes, input logic stall, input logic flush);
    port_idx_t win;
    port_vec_t pend;
    addr_t     a;
    req_valid_i = strobes;
    req_i       = req_drv;
    bank_busy_i = stall;
    flush_i     = flush;
    pend        = m_pending;
    m_rsp_valid = (pend != '0) && !stall;
    if (m_rsp_valid) begin
      win         = pick_winner(pend, m_ptr);
      a           = m_req[win].addr;
      m_rsp.idx   = win;
      m_rsp.we    = m_req[win].we;
      m_rsp.rdata = ref_mem[a];
      m_rsp_known = ref_known[a];
      if (m_req[win].we) begin
        ref_mem[a]   = m_req[win].wdata;
        ref_known[a] = 1'b1;
      end
      m_pending[win] = 1'b0;
      m_ptr          = next_pointer(pend, m_ptr);
    end
    for (int p = 0; p < NP; p++) begin
      if (strobes[p]) begin
        m_pending[p] = 1'b1;
        m_req[p]     = req_drv[p];
      end
    end
    if (flush) begin
      m_pending = '0;
      m_ptr     = '0;
    end
    @(posedge clk_i);
    #1;
    check_busy(busy_o, m_pending);
    check_valid(rsp_valid_o, m_rsp_valid);
    if (m_rsp_valid) begin
      check_rsp(rsp_o, m_rsp, m_rsp_known);
    end
    // the log keeps what the DUT delivered for the order and count checks
    if (rsp_valid_o) begin
      rsp_log.push_back(rsp_o);
    end
  endtask

  // idle cycles until every port is free and the last response has been seen
  task automatic drain();
    while (busy_o != '0 || rsp_valid_o) begin
      step('0, 1'b0, 1'b0);
    end
  endtask

  task automatic preload_memory();
    for (int r = 0; r < DEPTH / NP; r++) begin
      for (int p = 0; p < NP; p++) begin
        req_drv[p].we    = 1'b1;
        req_drv[p].addr  = addr_t'(r * NP + p);
        req_drv[p].wdata = fill_word(addr_t'(r * NP + p));
      end
      step('1, 1'b0, 1'b0);
      drain();
    end
  endtask

  // all ports strobe together with the pointer on port 0
  // even ports write and the odd port above reads the word back
  task automatic run_full_burst(input addr_t base);
    rsp_log.delete();
    for (int p = 0; p < NP; p++) begin
      req_drv[p].we    = (p % 2) == 0;
      req_drv[p].addr  = base + addr_t'(p - (p % 2));
      req_drv[p].wdata = data_t'(32'h1000_0000 + p);
    end
    step('1, 1'b0, 1'b0);
    check_busy(busy_o, '1);
    for (int k = 1; k <= NP; k++) begin
      step('0, 1'b0, 1'b0);
      check_busy(busy_o, port_vec_t'({NP{1'b1}} << k));
      check_valid(rsp_valid_o, 1'b1);
    end
    drain();
    if (rsp_log.size() != NP) begin
      mismatch($sformatf("burst gave %0d responses, expected %0d", rsp_log.size(), NP));
    end
    for (int i = 0; i < NP; i++) begin
      check_idx(rsp_log[i].idx, port_idx_t'(i));
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_single_port();
    mem_rsp_t exp;
    $display("test: single port write and read back");
    req_drv[1].we    = 1'b1;
    req_drv[1].addr  = addr_t'(5);
    req_drv[1].wdata = data_t'(32'hDEAD_BEEF);
    step(one_port(1), 1'b0, 1'b0);
    check_valid(rsp_valid_o, 1'b0);
    step('0, 1'b0, 1'b0);
    check_valid(rsp_valid_o, 1'b1);
    exp.idx   = port_idx_t'(1);
    exp.we    = 1'b1;
    exp.rdata = fill_word(addr_t'(5));
    check_rsp(rsp_o, exp, 1'b1);
    // busy has already dropped so the read goes out straight away
    req_drv[1].we = 1'b0;
    step(one_port(1), 1'b0, 1'b0);
    check_valid(rsp_valid_o, 1'b0);
    step('0, 1'b0, 1'b0);
    check_valid(rsp_valid_o, 1'b1);
    exp.we    = 1'b0;
    exp.rdata = data_t'(32'hDEAD_BEEF);
    check_rsp(rsp_o, exp, 1'b1);
  endtask

  task automatic test_full_burst();
    $display("test: full burst after reset");
    apply_reset();
    run_full_burst(addr_t'(20));
  endtask

  task automatic test_back_pressure();
    int order [4] = '{3, 0, 1, 2};
    $display("test: back-pressure from the bank");
    rsp_log.delete();
    // odd ports write words 10 and 11, even ports read them
    for (int p = 0; p < NP; p++) begin
      req_drv[p].we    = (p % 2) == 1;
      req_drv[p].addr  = addr_t'(10 + p / 2);
      req_drv[p].wdata = data_t'(32'h3000_0000 + p);
    end
    step(one_port(1) | one_port(3), 1'b1, 1'b0);
    step(one_port(0) | one_port(2), 1'b1, 1'b0);
    repeat (3) begin
      step('0, 1'b1, 1'b0);
      check_valid(rsp_valid_o, 1'b0);
      check_busy(busy_o, '1);
    end
    drain();
    if (rsp_log.size() != NP) begin
      mismatch($sformatf("release gave %0d responses, expected %0d", rsp_log.size(), NP));
    end
    // the burst before left the pointer on port 3
    for (int i = 0; i < NP; i++) begin
      check_idx(rsp_log[i].idx, port_idx_t'(order[i]));
    end
  endtask

  task automatic test_flush();
    $display("test: flush of pending requests");
    // move the pointer away from port 0 first
    req_drv[3].we   = 1'b0;
    req_drv[3].addr = addr_t'(0);
    step(one_port(3), 1'b0, 1'b0);
    drain();
    step('1, 1'b1, 1'b0);
    step('0, 1'b1, 1'b0);
    step('0, 1'b1, 1'b1);
    check_busy(busy_o, '0);
    repeat (3) begin
      step('0, 1'b0, 1'b0);
      check_valid(rsp_valid_o, 1'b0);
    end
    run_full_burst(addr_t'(40));
  endtask

  task automatic test_random();
    int        issued;
    port_vec_t strobes;
    logic      stall;
    $display("test: random traffic");
    rsp_log.delete();
    issued = 0;
    while (issued < NUM_RANDOM) begin
      strobes = '0;
      for (int p = 0; p < NP; p++) begin
        if (!busy_o[p] && issued < NUM_RANDOM && ($urandom % 2) == 1) begin
          req_drv[p].we    = ($urandom % 2) == 1;
          req_drv[p].addr  = addr_t'($urandom);
          req_drv[p].wdata = data_t'($urandom);
          strobes[p]       = 1'b1;
          issued++;
        end
      end
      stall = ($urandom % 8) == 0;
      step(strobes, stall, 1'b0);
    end
    drain();
    if (rsp_log.size() != NUM_RANDOM) begin
      mismatch($sformatf("random traffic gave %0d responses, expected %0d",
                         rsp_log.size(), NUM_RANDOM));
    end
  endtask

  initial begin : p_main
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    bank_busy_i = 1'b0;
    req_valid_i = '0;
    req_i       = '0;
    req_drv     = '0;
    m_req       = '0;
    for (int a = 0; a < DEPTH; a++) begin
      ref_mem[a]   = '0;
      ref_known[a] = 1'b0;
    end
    void'($urandom(59));
    apply_reset();
    preload_memory();
    test_single_port();
    test_full_burst();
    test_back_pressure();
    test_flush();
    test_random();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/arb_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lzc.sv
verilog/rr_arb_tree.sv
verilog/port_req_reg.sv
verilog/sram_bank.sv
verilog/shmem_top.sv
verif/tb_shmem.sv

//--- Makefile
# Verilator build and run of the shared memory testbench

TOP = tb_shmem

sim:
	rm -f sim.log
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
